//--- all.f
source/decode_pkg.sv
source/decode_ctrl_if.sv
source/stage_latch.sv
source/inst_decoder.sv
source/regfile.sv
source/operand_forward.sv
source/branch_unit.sv
source/decode_stage.sv
dv/decode_stage_tb.sv

//--- dv/decode_cases.txt
# W reg data | D inst pc next_pc exe_dest mem_dest wb_dest exe_res mem_res wb_res load allowin
# D is followed by: alu_op imm_ext dest gr_we mem_we load_op rs rt taken target stall valid allowin
# H load allowin, then the same expected fields on the line; target counts only when taken
W 00 deadbeef
W 01 00000011
W 02 00000022
W 03 00000011
W 04 80001000
W 05 0000abcd
D 00223021 00001000 00001004 00 00 00 00000000 00000000 00000000 0 1
  0 0 06 1 0 0 00000011 00000022 0 00000000 0 1 1
D 2422fff0 00001004 00001008 00 00 00 00000000 00000000 00000000 0 1
  0 2 02 1 0 0 00000011 00000022 0 00000000 0 1 1
D 34431234 00001008 0000100c 00 00 00 00000000 00000000 00000000 0 1
  6 1 03 1 0 0 00000022 00000011 0 00000000 0 1 1
D 3c04beef 0000100c 00001010 00 00 00 00000000 00000000 00000000 0 1
  b 1 04 1 0 0 00000000 80001000 0 00000000 0 1 1
D 8ca10008 00001010 00001014 00 00 00 00000000 00000000 00000000 0 1
  0 2 01 1 0 1 0000abcd 00000011 0 00000000 0 1 1
D ac22fffc 00001014 00001018 00 00 00 00000000 00000000 00000000 0 1
  0 2 00 0 1 0 00000011 00000022 0 00000000 0 1 1
D 00003825 00001018 0000101c 00 00 00 11111111 22222222 33333333 0 1
  6 0 07 1 0 0 00000000 00000000 0 00000000 0 1 1
D 00223021 00001020 00001024 01 01 02 aaaa0001 bbbb0001 cccc0002 0 1
  0 0 06 1 0 0 aaaa0001 cccc0002 0 00000000 0 1 1
D 00223021 00001024 00001028 00 02 02 ffffffff bbbb0002 cccc0002 0 1
  0 0 06 1 0 0 00000011 bbbb0002 0 00000000 0 1 1
D 00223021 00001028 0000102c 02 00 00 12345678 00000000 00000000 1 1
  0 0 06 1 0 0 00000011 12345678 0 00000000 0 0 0
H 1 1 0 0 06 1 0 0 00000011 12345678 0 00000000 0 0 0
H 0 1 0 0 06 1 0 0 00000011 12345678 0 00000000 0 1 1
D 10230010 00002000 00002004 03 00 00 00000011 00000000 00000000 1 1
  c 0 00 0 0 0 00000011 00000011 1 00002044 1 0 0
H 0 1 c 0 00 0 0 0 00000011 00000011 1 00002044 0 1 1
D 10220010 00002008 0000200c 00 00 00 00000000 00000000 00000000 0 1
  c 0 00 0 0 0 00000011 00000022 0 00000000 0 1 1
D 1422fffe 00003000 00003004 00 00 00 00000000 00000000 00000000 0 1
  c 0 00 0 0 0 00000011 00000022 1 00002ffc 0 1 1
D 1423fffe 00003000 00003004 00 01 00 00000000 00000099 00000000 0 1
  c 0 00 0 0 0 00000099 00000011 1 00002ffc 0 1 1
D 08000040 40000000 40000004 00 00 00 00000000 00000000 00000000 0 1
  c 0 00 0 0 0 00000000 00000000 1 40000100 0 1 1
D 0c000080 00004000 00004004 00 00 00 00000000 00000000 00000000 0 1
  0 0 1f 1 0 0 00000000 00000000 1 00000200 0 1 1
D 00800008 00005000 00005004 00 00 00 00000000 00000000 00000000 0 1
  c 0 00 0 0 0 80001000 00000000 1 80001000 0 1 1
D 00253026 00006000 00006004 00 00 00 00000000 00000000 00000000 0 0
  7 0 06 1 0 0 00000011 0000abcd 0 00000000 0 1 0
H 0 0 7 0 06 1 0 0 00000011 0000abcd 0 00000000 0 1 0
H 0 1 7 0 06 1 0 0 00000011 0000abcd 0 00000000 0 1 1

//--- dv/decode_stage_tb.sv
module decode_stage_tb;

    localparam int    reset_cycles    = 10;
    localparam int    cycles_per_line = 40;  // generous bound per cases-file line
    localparam string cases_file      = "dv/decode_cases.txt";

    logic                 clk;
    logic                 reset;
    logic                 fs_to_ds_valid;
    logic [31:0]          fs_pc;
    logic [31:0]          fs_inst;
    logic [31:0]          fetch_next_pc;
    logic                 es_allowin;
    logic                 rf_we;
    logic [4:0]           rf_waddr;
    logic [31:0]          rf_wdata;
    logic [4:0]           exe_dest;
    logic [4:0]           mem_dest;
    logic [4:0]           wb_dest;
    logic [31:0]          exe_result;
    logic [31:0]          mem_result;
    logic [31:0]          wb_result;
    logic                 es_load_op;

    logic                 ds_allowin;
    logic                 ds_to_es_valid;
    decode_pkg::alu_op_e  alu_op;
    decode_pkg::imm_ext_e imm_ext;
    logic                 src1_is_sa;
    logic                 src1_is_pc;
    logic                 src2_is_8;
    logic                 load_op;
    logic                 gr_we;
    logic                 mem_we;
    logic [4:0]           dest;
    logic [15:0]          imm;
    logic [31:0]          rs_value;
    logic [31:0]          rt_value;
    logic [31:0]          ds_pc;
    logic                 br_taken;
    logic [31:0]          br_target;
    logic                 br_stall;

    int          fd;
    int          cycle_count = 0;
    int          cycle_limit = reset_cycles + cycles_per_line;
    logic [31:0] last_pc;    // pc of the instruction held in decode
    logic [31:0] last_inst;  // instruction held in decode

    decode_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            stop_on_error($sformatf("timeout, no end of test after %0d cycles", cycle_count));
        end
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            stop_on_error($sformatf("FAIL t=%0t %s got %h expected %h",
                                    $time, name, got, expected));
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        rf_we    = 1'b1;
        rf_waddr = addr;
        rf_wdata = data;
        @(negedge clk);  // written on the edge in between
        rf_we    = 1'b0;
    endtask

    // hand one instruction to decode with a clean pipeline behind it
    task automatic accept_inst(input logic [31:0] inst, input logic [31:0] pc,
                               input logic [31:0] next_pc);
        @(negedge clk);
        fs_to_ds_valid = 1'b1;
        fs_inst        = inst;
        fs_pc          = pc;
        fetch_next_pc  = next_pc;
        es_allowin     = 1'b1;
        es_load_op     = 1'b0;
        exe_dest       = '0;
        mem_dest       = '0;
        wb_dest        = '0;
        #1;
        while (!ds_allowin) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);  // taken here
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        last_pc        = pc;
        last_inst      = inst;
    endtask

    task automatic check_expected();
        logic [3:0]  e_alu_op;
        logic [1:0]  e_imm_ext;
        logic [4:0]  e_dest;
        logic        e_gr_we;
        logic        e_mem_we;
        logic        e_load_op;
        logic [31:0] e_rs;
        logic [31:0] e_rt;
        logic        e_taken;
        logic [31:0] e_target;
        logic        e_stall;
        logic        e_valid;
        logic        e_allowin;
        logic        e_shift;
        logic        e_link;
        int          n;
        n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                    e_alu_op, e_imm_ext, e_dest, e_gr_we, e_mem_we, e_load_op,
                    e_rs, e_rt, e_taken, e_target, e_stall, e_valid, e_allowin);
        if (n != 13) begin
            stop_on_error("expected values in the cases file are missing or malformed");
        end
        e_shift = e_alu_op inside {4'h8, 4'h9, 4'ha};  // sll, srl, sra shift by sa
        e_link  = e_taken && e_gr_we;  // jal is the only taken op that writes
        check_value("alu_op", 32'(alu_op), 32'(e_alu_op));
        check_value("imm_ext", 32'(imm_ext), 32'(e_imm_ext));
        check_value("dest", 32'(dest), 32'(e_dest));
        check_value("gr_we", 32'(gr_we), 32'(e_gr_we));
        check_value("mem_we", 32'(mem_we), 32'(e_mem_we));
        check_value("load_op", 32'(load_op), 32'(e_load_op));
        check_value("src1_is_sa", 32'(src1_is_sa), 32'(e_shift));
        check_value("src1_is_pc", 32'(src1_is_pc), 32'(e_link));
        check_value("src2_is_8", 32'(src2_is_8), 32'(e_link));
        check_value("imm", 32'(imm), 32'(last_inst[15:0]));
        check_value("rs_value", rs_value, e_rs);
        check_value("rt_value", rt_value, e_rt);
        check_value("ds_pc", ds_pc, last_pc);
        check_value("br_taken", 32'(br_taken), 32'(e_taken));
        if (e_taken) begin
            check_value("br_target", br_target, e_target);  // only meaningful when taken
        end
        check_value("br_stall", 32'(br_stall), 32'(e_stall));
        check_value("ds_to_es_valid", 32'(ds_to_es_valid), 32'(e_valid));
        check_value("ds_allowin", 32'(ds_allowin), 32'(e_allowin));
    endtask

    initial begin
        int          ch;
        int          n;
        int          n_lines;
        int          n_cases;
        logic [7:0]  tag;
        logic [4:0]  w_addr;
        logic [31:0] w_data;
        logic [31:0] d_inst;
        logic [31:0] d_pc;
        logic [31:0] d_next_pc;
        logic [4:0]  d_exe_dest;
        logic [4:0]  d_mem_dest;
        logic [4:0]  d_wb_dest;
        logic [31:0] d_exe_result;
        logic [31:0] d_mem_result;
        logic [31:0] d_wb_result;
        logic        d_load;
        logic        d_allowin;

        reset          = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_pc          = '0;
        fs_inst        = '0;
        fetch_next_pc  = '0;
        es_allowin     = 1'b1;
        rf_we          = 1'b0;
        rf_waddr       = '0;
        rf_wdata       = '0;
        exe_dest       = '0;
        mem_dest       = '0;
        wb_dest        = '0;
        exe_result     = '0;
        mem_result     = '0;
        wb_result      = '0;
        es_load_op     = 1'b0;
        last_pc        = '0;
        last_inst      = '0;
        n_cases        = 0;

        fd = $fopen(cases_file, "r");
        if (fd == 0) begin
            stop_on_error("could not open the cases file dv/decode_cases.txt");
        end
        n_lines = 0;
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == 10) n_lines++;
            ch = $fgetc(fd);
        end
        $fclose(fd);
        cycle_limit = reset_cycles + cycles_per_line * n_lines;
        fd = $fopen(cases_file, "r");

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_value("ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);  // empty after reset
        check_value("ds_allowin", 32'(ds_allowin), 32'd1);

        n = $fscanf(fd, " %c", tag);
        while (n == 1) begin
            case (tag)
                "#": begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) ch = $fgetc(fd);
                end
                "W": begin
                    n = $fscanf(fd, "%h %h", w_addr, w_data);
                    if (n != 2) stop_on_error("malformed register write in the cases file");
                    write_reg(w_addr, w_data);
                end
                "D": begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h",
                                d_inst, d_pc, d_next_pc, d_exe_dest, d_mem_dest, d_wb_dest,
                                d_exe_result, d_mem_result, d_wb_result, d_load, d_allowin);
                    if (n != 11) stop_on_error("malformed decode case in the cases file");
                    accept_inst(d_inst, d_pc, d_next_pc);
                    exe_dest   = d_exe_dest;  // hazard state seen by the held instruction
                    mem_dest   = d_mem_dest;
                    wb_dest    = d_wb_dest;
                    exe_result = d_exe_result;
                    mem_result = d_mem_result;
                    wb_result  = d_wb_result;
                    es_load_op = d_load;
                    es_allowin = d_allowin;
                    #1;
                    check_expected();
                    n_cases++;
                end
                "H": begin
                    n = $fscanf(fd, "%h %h", d_load, d_allowin);
                    if (n != 2) stop_on_error("malformed hold step in the cases file");
                    @(negedge clk);
                    es_load_op     = d_load;
                    es_allowin     = d_allowin;
                    fs_to_ds_valid = 1'b1;  // competing fetch must not replace the held one
                    fs_inst        = ~last_inst;
                    fs_pc          = ~last_pc;
                    #1;
                    check_expected();
                end
                default: stop_on_error($sformatf("unknown line tag %c in the cases file", tag));
            endcase
            n = $fscanf(fd, " %c", tag);
        end
        $fclose(fd);

        if (n_cases == 0) begin
            stop_on_error("the cases file holds no decode cases");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module decode_stage_tb \
    -o decode_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/decode_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- source/branch_unit.sv
module branch_unit (
    decode_ctrl_if.branch     ctrl,
    input  decode_pkg::word_t rs_value,
    input  decode_pkg::word_t rt_value,
    input  decode_pkg::word_t fetch_next_pc,
    input  logic              load_stall,
    output logic              br_taken,
    output decode_pkg::word_t br_target,
    output logic              br_stall
);
    import decode_pkg::*;

    logic  rs_eq_rt;
    word_t branch_off;
    word_t jump_addr;

    assign rs_eq_rt = rs_value == rt_value;

    assign br_taken = (ctrl.is_beq && rs_eq_rt)
                   || (ctrl.is_branch && !ctrl.is_beq && !rs_eq_rt)  // bne
                   || ctrl.is_jump
                   || ctrl.is_jr;

    // word offset, sign extended
    assign branch_off = {{(data_w-18){ctrl.imm[15]}}, ctrl.imm, 2'b00};
    assign jump_addr  = {fetch_next_pc[data_w-1:data_w-4], ctrl.jidx, 2'b00};

    always_comb begin
        if (ctrl.is_branch) begin
            br_target = fetch_next_pc + branch_off;
        end else if (ctrl.is_jr) begin
            br_target = rs_value;
        end else begin
            br_target = jump_addr;  // j, jal
        end
    end

    // fetch must not follow a target built from a stale operand
    assign br_stall = br_taken && load_stall;

endmodule

//--- source/decode_ctrl_if.sv
interface decode_ctrl_if;
    import decode_pkg::*;

    reg_addr_t   rs;
    reg_addr_t   rt;
    logic        uses_rs;     // rs is a real operand
    logic        uses_rt;     // rt is a real operand
    logic        is_branch;   // beq or bne
    logic        is_jump;     // j or jal
    logic        is_jr;
    logic        is_beq;
    logic [15:0] imm;
    logic [25:0] jidx;

    modport decoder (
        output rs, rt, uses_rs, uses_rt,
        output is_branch, is_jump, is_jr, is_beq, imm, jidx
    );

    modport forward (input rs, rt, uses_rs, uses_rt);

    modport branch (input is_branch, is_jump, is_jr, is_beq, imm, jidx);

endinterface

//--- source/decode_pkg.sv
package decode_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;

    typedef logic [data_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    localparam reg_addr_t rf_zero  = 5'd0;
    localparam reg_addr_t link_reg = 5'd31;  // jal writes the return address here

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addi    = 6'h08,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // function field of special, inst[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_jr   = 6'h08,
        fn_add  = 6'h20,
        fn_addu = 6'h21,
        fn_sub  = 6'h22,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui,
        alu_none  // branches and jumps without a result
    } alu_op_e;

    typedef enum logic [1:0] {
        imm_none = 2'b00,
        imm_zero = 2'b01,
        imm_sign = 2'b10
    } imm_ext_e;

endpackage

//--- source/decode_stage.sv
module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fs_to_ds_valid,
    input  decode_pkg::word_t     fs_pc,
    input  decode_pkg::word_t     fs_inst,
    input  decode_pkg::word_t     fetch_next_pc,
    input  logic                  es_allowin,
    input  logic                  rf_we,
    input  decode_pkg::reg_addr_t rf_waddr,
    input  decode_pkg::word_t     rf_wdata,
    input  decode_pkg::reg_addr_t exe_dest,
    input  decode_pkg::reg_addr_t mem_dest,
    input  decode_pkg::reg_addr_t wb_dest,
    input  decode_pkg::word_t     exe_result,
    input  decode_pkg::word_t     mem_result,
    input  decode_pkg::word_t     wb_result,
    input  logic                  es_load_op,
    output logic                  ds_allowin,
    output logic                  ds_to_es_valid,
    output decode_pkg::alu_op_e   alu_op,
    output decode_pkg::imm_ext_e  imm_ext,
    output logic                  src1_is_sa,
    output logic                  src1_is_pc,
    output logic                  src2_is_8,
    output logic                  load_op,
    output logic                  gr_we,
    output logic                  mem_we,
    output decode_pkg::reg_addr_t dest,
    output logic [15:0]           imm,
    output decode_pkg::word_t     rs_value,
    output decode_pkg::word_t     rt_value,
    output decode_pkg::word_t     ds_pc,
    output logic                  br_taken,
    output decode_pkg::word_t     br_target,
    output logic                  br_stall
);
    import decode_pkg::*;

    word_t ds_inst;
    word_t rf_rdata1;
    word_t rf_rdata2;
    logic  load_stall;

    decode_ctrl_if ctrl ();

    stage_latch u_latch (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .es_allowin     (es_allowin),
        .load_stall     (load_stall),
        .allowin        (ds_allowin),
        .out_valid      (ds_to_es_valid),
        .inst           (ds_inst),
        .pc             (ds_pc)
    );

    inst_decoder u_decoder (
        .inst       (ds_inst),
        .ctrl       (ctrl.decoder),
        .alu_op     (alu_op),
        .imm_ext    (imm_ext),
        .src1_is_sa (src1_is_sa),
        .src1_is_pc (src1_is_pc),
        .src2_is_8  (src2_is_8),
        .load_op    (load_op),
        .gr_we      (gr_we),
        .mem_we     (mem_we),
        .dest       (dest),
        .imm        (imm)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (ctrl.rs),
        .raddr2 (ctrl.rt),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    operand_forward u_forward (
        .ctrl       (ctrl.forward),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .exe_dest   (exe_dest),
        .mem_dest   (mem_dest),
        .wb_dest    (wb_dest),
        .exe_result (exe_result),
        .mem_result (mem_result),
        .wb_result  (wb_result),
        .es_load_op (es_load_op),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .load_stall (load_stall)
    );

    branch_unit u_branch (
        .ctrl          (ctrl.branch),
        .rs_value      (rs_value),
        .rt_value      (rt_value),
        .fetch_next_pc (fetch_next_pc),
        .load_stall    (load_stall),
        .br_taken      (br_taken),
        .br_target     (br_target),
        .br_stall      (br_stall)
    );

endmodule

//--- source/inst_decoder.sv
module inst_decoder (
    input  decode_pkg::word_t     inst,
    decode_ctrl_if.decoder        ctrl,
    output decode_pkg::alu_op_e   alu_op,
    output decode_pkg::imm_ext_e  imm_ext,
    output logic                  src1_is_sa,
    output logic                  src1_is_pc,
    output logic                  src2_is_8,
    output logic                  load_op,
    output logic                  gr_we,
    output logic                  mem_we,
    output decode_pkg::reg_addr_t dest,
    output logic [15:0]           imm
);
    import decode_pkg::*;

    opcode_e   op;
    funct_e    fn;
    reg_addr_t rs, rt, rd, sa;
    logic      r_sa0, r_rs0;
    logic      m_addu, m_subu, m_add, m_sub, m_slt, m_sltu, m_and;
    logic      m_or, m_xor, m_nor, m_sll, m_srl, m_sra, m_jr;
    logic      m_addiu, m_addi, m_slti, m_sltiu, m_andi, m_ori, m_xori;
    logic      m_lui, m_lw, m_sw, m_beq, m_bne, m_j, m_jal;
    logic      r_alu, i_alu, no_dest;
    logic [27:0] match_vec;

    assign op = opcode_e'(inst[31:26]);
    assign rs = inst[25:21];
    assign rt = inst[20:16];
    assign rd = inst[15:11];
    assign sa = inst[10:6];
    assign fn = funct_e'(inst[5:0]);

    assign r_sa0 = (op == op_special) && (sa == rf_zero);  // register ops
    assign r_rs0 = (op == op_special) && (rs == rf_zero);  // shifts by sa

    assign m_addu  = r_sa0 && fn == fn_addu;
    assign m_subu  = r_sa0 && fn == fn_subu;
    assign m_add   = r_sa0 && fn == fn_add;
    assign m_sub   = r_sa0 && fn == fn_sub;
    assign m_slt   = r_sa0 && fn == fn_slt;
    assign m_sltu  = r_sa0 && fn == fn_sltu;
    assign m_and   = r_sa0 && fn == fn_and;
    assign m_or    = r_sa0 && fn == fn_or;
    assign m_xor   = r_sa0 && fn == fn_xor;
    assign m_nor   = r_sa0 && fn == fn_nor;
    assign m_sll   = r_rs0 && fn == fn_sll;
    assign m_srl   = r_rs0 && fn == fn_srl;
    assign m_sra   = r_rs0 && fn == fn_sra;
    assign m_jr    = r_sa0 && fn == fn_jr && rt == rf_zero && rd == rf_zero;
    assign m_addiu = op == op_addiu;
    assign m_addi  = op == op_addi;
    assign m_slti  = op == op_slti;
    assign m_sltiu = op == op_sltiu;
    assign m_andi  = op == op_andi;
    assign m_ori   = op == op_ori;
    assign m_xori  = op == op_xori;
    assign m_lui   = op == op_lui && rs == rf_zero;
    assign m_lw    = op == op_lw;
    assign m_sw    = op == op_sw;
    assign m_beq   = op == op_beq;
    assign m_bne   = op == op_bne;
    assign m_j     = op == op_j;
    assign m_jal   = op == op_jal;

    assign match_vec = {m_addu, m_subu, m_add, m_sub, m_slt, m_sltu, m_and,
                        m_or, m_xor, m_nor, m_sll, m_srl, m_sra, m_jr,
                        m_addiu, m_addi, m_slti, m_sltiu, m_andi, m_ori, m_xori,
                        m_lui, m_lw, m_sw, m_beq, m_bne, m_j, m_jal};

    assign r_alu   = m_addu | m_subu | m_add | m_sub | m_slt | m_sltu | m_and
                   | m_or | m_xor | m_nor | m_sll | m_srl | m_sra;
    assign i_alu   = m_addiu | m_addi | m_slti | m_sltiu | m_andi | m_ori | m_xori;
    assign no_dest = m_sw | m_beq | m_bne | m_j | m_jr;

    always_comb begin
        if (m_addu | m_add | m_addiu | m_addi | m_lw | m_sw | m_jal) alu_op = alu_add;
        else if (m_subu | m_sub)   alu_op = alu_sub;
        else if (m_slt | m_slti)   alu_op = alu_slt;
        else if (m_sltu | m_sltiu) alu_op = alu_sltu;
        else if (m_and | m_andi)   alu_op = alu_and;
        else if (m_nor)            alu_op = alu_nor;
        else if (m_or | m_ori)     alu_op = alu_or;
        else if (m_xor | m_xori)   alu_op = alu_xor;
        else if (m_sll)            alu_op = alu_sll;
        else if (m_srl)            alu_op = alu_srl;
        else if (m_sra)            alu_op = alu_sra;
        else if (m_lui)            alu_op = alu_lui;
        else                       alu_op = alu_none;  // branches, j, jr
    end

    always_comb begin
        if (m_andi | m_ori | m_xori | m_lui) imm_ext = imm_zero;
        else if (m_addiu | m_addi | m_slti | m_sltiu | m_lw | m_sw) imm_ext = imm_sign;
        else imm_ext = imm_none;
    end

    always_comb begin
        if (m_jal)                      dest = link_reg;
        else if (i_alu | m_lui | m_lw)  dest = rt;
        else if (no_dest)               dest = rf_zero;
        else                            dest = rd;
    end

    assign gr_we      = dest != rf_zero;
    assign mem_we     = m_sw;
    assign load_op    = m_lw;
    assign src1_is_sa = m_sll | m_srl | m_sra;
    assign src1_is_pc = m_jal;  // link value is pc + 8
    assign src2_is_8  = m_jal;
    assign imm        = inst[15:0];

    assign ctrl.rs        = rs;
    assign ctrl.rt        = rt;
    assign ctrl.uses_rs   = (|match_vec) && !(m_j | m_jal);
    assign ctrl.uses_rt   = r_alu | m_sw | m_beq | m_bne;
    assign ctrl.is_branch = m_beq | m_bne;
    assign ctrl.is_jump   = m_j | m_jal;
    assign ctrl.is_jr     = m_jr;
    assign ctrl.is_beq    = m_beq;
    assign ctrl.imm       = inst[15:0];
    assign ctrl.jidx      = inst[25:0];

    always_comb begin
        a_one_match: assert ($onehot0(match_vec));
    end

endmodule

//--- source/operand_forward.sv
module operand_forward (
    decode_ctrl_if.forward        ctrl,
    input  decode_pkg::word_t     rf_rdata1,
    input  decode_pkg::word_t     rf_rdata2,
    input  decode_pkg::reg_addr_t exe_dest,
    input  decode_pkg::reg_addr_t mem_dest,
    input  decode_pkg::reg_addr_t wb_dest,
    input  decode_pkg::word_t     exe_result,
    input  decode_pkg::word_t     mem_result,
    input  decode_pkg::word_t     wb_result,
    input  logic                  es_load_op,
    output decode_pkg::word_t     rs_value,
    output decode_pkg::word_t     rt_value,
    output logic                  load_stall
);
    import decode_pkg::*;

    logic rs_wait;
    logic rt_wait;

    // a source waits when a later stage still owes it a value
    function automatic logic src_wait(input logic used, input reg_addr_t src);
        return used && (src != rf_zero)
            && (src == exe_dest || src == mem_dest || src == wb_dest);
    endfunction

    // youngest producer wins
    function automatic word_t src_value(input logic waiting, input reg_addr_t src,
                                        input word_t rf_value);
        if (!waiting) begin
            return rf_value;
        end else if (src == exe_dest) begin
            return exe_result;
        end else if (src == mem_dest) begin
            return mem_result;
        end
        return wb_result;
    endfunction

    assign rs_wait  = src_wait(ctrl.uses_rs, ctrl.rs);
    assign rt_wait  = src_wait(ctrl.uses_rt, ctrl.rt);

    assign rs_value = src_value(rs_wait, ctrl.rs, rf_rdata1);
    assign rt_value = src_value(rt_wait, ctrl.rt, rf_rdata2);

    // load data only exists after mem, so exe cannot forward it
    assign load_stall = es_load_op
                      && ((rs_wait && ctrl.rs == exe_dest)
                       || (rt_wait && ctrl.rt == exe_dest));

endmodule

//--- source/regfile.sv
module regfile (
    input  logic                  clk,
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    input  logic                  we,
    input  decode_pkg::reg_addr_t waddr,
    input  decode_pkg::word_t     wdata,
    output decode_pkg::word_t     rdata1,
    output decode_pkg::word_t     rdata2
);
    import decode_pkg::*;

    word_t rf [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (we && waddr != rf_zero) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 is hardwired, same-cycle write-back comes through forwarding
    assign rdata1 = (raddr1 == rf_zero) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == rf_zero) ? '0 : rf[raddr2];

endmodule

//--- source/stage_latch.sv
module stage_latch (
    input  logic               clk,
    input  logic               reset,
    input  logic               fs_to_ds_valid,
    input  decode_pkg::word_t  fs_pc,
    input  decode_pkg::word_t  fs_inst,
    input  logic               es_allowin,
    input  logic               load_stall,
    output logic               allowin,
    output logic               out_valid,
    output decode_pkg::word_t  inst,
    output decode_pkg::word_t  pc
);
    logic valid;
    logic ready_go;

    assign ready_go  = !load_stall;
    assign allowin   = !valid || (ready_go && es_allowin);
    assign out_valid = valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= fs_to_ds_valid;  // empty when fetch has nothing
        end
    end

    // inst clears to sll r0 so the decode is a nop after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            inst <= '0;
            pc   <= '0;
        end else if (fs_to_ds_valid && allowin) begin
            inst <= fs_inst;
            pc   <= fs_pc;
        end
    end

    // fetch keeps offering until the latch takes it
    a_fetch_holds: assert property (@(posedge clk) disable iff (reset)
        fs_to_ds_valid && !allowin |=> fs_to_ds_valid);

    a_empty_after_reset: assert property (@(posedge clk) reset |=> !out_valid);

endmodule
